//--- design/osdParams.svh
// OSD parameters
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// ******************************
// overlay window
// ******************************
`define OSD_WIDTH        256
`define OSD_HEIGHT       128
`define OSD_X_OFFSET     0
`define OSD_Y_OFFSET     0

// two bits per channel, r g b
`define OSD_COLOR        6'h3C

// ******************************
// widths
// ******************************
`define COLOR_W          6
`define CNT_W            10
`define BUF_AW           11

// above this many active lines each overlay line is shown twice
`define DOUBLESCAN_LINES 350

// spi command opcodes
`define CMD_WRITE        5'b00100
`define CMD_ENABLE       7'b0100000
`endif

//--- design/osdPkg.sv
// OSD types
`default_nettype none
`include "osdParams.svh"

package osdPkg;

	typedef struct packed {
		logic [`COLOR_W-1:0] red;
		logic [`COLOR_W-1:0] green;
		logic [`COLOR_W-1:0] blue;
		logic                hSync;
		logic                vSync;
	} vgaPixel_t;

	typedef struct packed {
		logic [`CNT_W-1:0] hStart;
		logic [`CNT_W-1:0] hEnd;
		logic [`CNT_W-1:0] vStart;
		logic [`CNT_W-1:0] vEnd;
		logic              hsPol;
		logic              vsPol;
		logic              doubleScan;
	} osdWindow_t;

	typedef struct packed {
		logic [`CNT_W-1:0] hCount;
		logic [`CNT_W-1:0] vCount;
	} videoPos_t;

	typedef struct packed {
		logic               valid;
		logic [`BUF_AW-1:0] addr;
		logic [7:0]         data;
	} bufWrite_t;

	// one command byte, read either as a write or as an enable
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [4:0] opcode;
			logic [2:0] line;
		} writeView;
		struct packed {
			logic [6:0] opcode;
			logic       on;
		} enableView;
	} spiCmd_u;

endpackage

`default_nettype wire

//--- design/osdSpiRx.sv
// OSD SPI command receiver
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdSpiRx (
	input  logic              SPI_SCK,
	input  logic              SPI_SS3,
	input  logic              SPI_DI,
	output osdPkg::bufWrite_t bufWr,
	output logic              osdEnable
);
	import osdPkg::*;

	logic [3:0]         bitCnt;
	logic [6:0]         shiftReg;
	logic [7:0]         rxByte;
	logic [`BUF_AW-1:0] wrAddr;
	logic               wrBeat;
	logic               enableReg = 1'b0;
	spiCmd_u            cmd;
	spiCmd_u            cmdNext;

	// byte completes with the bit arriving on this edge
	assign rxByte      = {shiftReg, SPI_DI};
	assign cmdNext.raw = rxByte;

	assign wrBeat    = (bitCnt == 4'd15) && (cmd.writeView.opcode == `CMD_WRITE);
	assign bufWr     = '{valid: wrBeat, addr: wrAddr, data: rxByte};
	assign osdEnable = enableReg;

	// bits 0..7 are the command, then payload bytes at 8..15
	always_ff @(posedge SPI_SCK or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			bitCnt <= '0;
			wrAddr <= '0;
		end else begin
			if (bitCnt == 4'd15)
				bitCnt <= 4'd8;
			else
				bitCnt <= bitCnt + 4'd1;

			if ((bitCnt == 4'd7) && (cmdNext.writeView.opcode == `CMD_WRITE))
				wrAddr <= {cmdNext.writeView.line, 8'h00};
			else if (wrBeat)
				wrAddr <= wrAddr + 1'b1;
		end
	end

	always_ff @(posedge SPI_SCK) begin
		shiftReg <= rxByte[6:0];
		if (bitCnt == 4'd7) begin
			cmd <= cmdNext;
			// enable takes effect on the last command bit
			if (cmdNext.enableView.opcode == `CMD_ENABLE)
				enableReg <= cmdNext.enableView.on;
		end
	end

endmodule

`default_nettype wire

//--- design/osdSyncMeasure.sv
// OSD video timing analysis
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdSyncMeasure (
	input  logic               clk_sys,
	input  osdPkg::vgaPixel_t  videoIn,
	output osdPkg::videoPos_t  pos,
	output osdPkg::osdWindow_t window
);
	import osdPkg::*;

	localparam logic [`CNT_W-1:0] OSD_W = `OSD_WIDTH;
	localparam logic [`CNT_W-1:0] OSD_H = `OSD_HEIGHT;
	localparam logic [`CNT_W-1:0] X_OFS = `OSD_X_OFFSET;
	localparam logic [`CNT_W-1:0] Y_OFS = `OSD_Y_OFFSET;

	logic [1:0]        hsD = '0;
	logic [1:0]        vsD = '0;
	logic [`CNT_W-1:0] hCount = '0;
	logic [`CNT_W-1:0] vCount = '0;
	logic [`CNT_W-1:0] hsHigh = '0;
	logic [`CNT_W-1:0] hsLow = '0;
	logic [`CNT_W-1:0] vsHigh = '0;
	logic [`CNT_W-1:0] vsLow = '0;
	logic [`CNT_W-1:0] dspWidth = '0;
	logic [`CNT_W-1:0] dspHeight = '0;
	logic [`CNT_W-1:0] winHeight;
	osdWindow_t        winReg = '0;

	assign pos       = '{hCount: hCount, vCount: vCount};
	assign window    = winReg;
	assign winHeight = winReg.doubleScan ? (OSD_H << 1) : OSD_H;

	// ******************************
	// line and frame counters
	// ******************************
	always_ff @(posedge clk_sys) begin
		hsD <= {hsD[0], videoIn.hSync};
		vsD <= {vsD[0], videoIn.vSync};

		if (hsD == 2'b10) begin
			hCount <= '0;
			hsHigh <= hCount;
		end else if (hsD == 2'b01) begin
			hCount <= '0;
			hsLow  <= hCount;
		end else begin
			hCount <= hCount + 1'b1;
		end

		// lines are counted on the hsync rising edge
		if (vsD == 2'b10) begin
			vCount <= '0;
			vsHigh <= vCount;
		end else if (vsD == 2'b01) begin
			vCount <= '0;
			vsLow  <= vCount;
		end else if (hsD == 2'b01) begin
			vCount <= vCount + 1'b1;
		end
	end

	// ******************************
	// polarity, size and window
	// ******************************
	always_ff @(posedge clk_sys) begin
		// the shorter phase is the sync pulse
		winReg.hsPol      <= hsHigh < hsLow;
		winReg.vsPol      <= vsHigh < vsLow;
		dspWidth          <= winReg.hsPol ? hsLow : hsHigh;
		dspHeight         <= winReg.vsPol ? vsLow : vsHigh;
		winReg.doubleScan <= dspHeight > `DOUBLESCAN_LINES;

		winReg.hStart <= ((dspWidth - OSD_W) >> 1) + X_OFS;
		winReg.hEnd   <= winReg.hStart + OSD_W;
		winReg.vStart <= ((dspHeight - winHeight) >> 1) + Y_OFS;
		winReg.vEnd   <= winReg.vStart + winHeight;
	end

endmodule

`default_nettype wire

//--- design/osdBuffer.sv
// OSD overlay memory
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdBuffer (
	input  logic               SPI_SCK,
	input  osdPkg::bufWrite_t  bufWr,
	input  logic               clk_sys,
	input  logic [`BUF_AW-1:0] rdAddr,
	output logic [7:0]         rdData
);

	logic [7:0] mem [0:(1 << `BUF_AW)-1];

	// write side in the spi clock domain
	always_ff @(posedge SPI_SCK) begin
		if (bufWr.valid)
			mem[bufWr.addr] <= bufWr.data;
	end

	// registered read for the pixel pipeline
	always_ff @(posedge clk_sys) begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

//--- design/osdPixelPath.sv
// OSD pixel fetch and colour mixer
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdPixelPath (
	input  logic               clk_sys,
	input  logic               osdEnable,
	input  osdPkg::vgaPixel_t  videoIn,
	input  osdPkg::videoPos_t  pos,
	input  osdPkg::osdWindow_t window,
	output logic [`BUF_AW-1:0] rdAddr,
	input  logic [7:0]         rdData,
	output osdPkg::vgaPixel_t  videoOut,
	output logic               osdShown
);

	localparam logic [5:0] TINT = `OSD_COLOR ^ 6'b010101;

	logic [1:0]        enSync = '0;
	logic              shownReg = 1'b0;
	logic              osdDe = 1'b0;
	logic              pixel;
	logic [`CNT_W-1:0] osdH;
	logic [`CNT_W-1:0] osdV;
	logic [`CNT_W-1:0] osdHNext2;
	logic [`CNT_W-1:0] hNext;
	logic [2:0]        bitSel;

	assign osdShown = shownReg;

	// window relative position, the byte is fetched two pixels ahead
	assign osdH      = pos.hCount - window.hStart;
	assign osdV      = pos.vCount - window.vStart;
	assign osdHNext2 = osdH + 2'd2;
	assign hNext     = pos.hCount + 1'b1;
	assign bitSel    = window.doubleScan ? osdV[4:2] : osdV[3:1];

	always_ff @(posedge clk_sys) begin
		enSync   <= {enSync[0], osdEnable};
		shownReg <= enSync[1];
	end

	// ******************************
	// fetch and window flag
	// ******************************
	always_ff @(posedge clk_sys) begin
		rdAddr <= {window.doubleScan ? osdV[7:5] : osdV[6:4], osdHNext2[7:0]};
		pixel  <= rdData[bitSel];
		osdDe  <= enSync[1] &&
			(videoIn.hSync != window.hsPol) &&
			(hNext >= window.hStart) && (hNext < window.hEnd) &&
			(videoIn.vSync != window.vsPol) &&
			(pos.vCount >= window.vStart) && (pos.vCount < window.vEnd);
	end

	// ******************************
	// colour mixer
	// ******************************
	always_ff @(posedge clk_sys) begin
		if (osdDe) begin
			videoOut.red   <= {{2{pixel}}, TINT[5:4], videoIn.red[5:4]};
			videoOut.green <= {{2{pixel}}, TINT[3:2], videoIn.green[5:4]};
			videoOut.blue  <= {{2{pixel}}, TINT[1:0], videoIn.blue[5:4]};
		end else begin
			videoOut.red   <= videoIn.red;
			videoOut.green <= videoIn.green;
			videoOut.blue  <= videoIn.blue;
		end
		videoOut.hSync <= videoIn.hSync;
		videoOut.vSync <= videoIn.vSync;
	end

endmodule

`default_nettype wire

//--- design/osdTop.sv
// OSD top level
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdTop (
	input  logic              clk_sys,
	input  logic              SPI_SCK,
	input  logic              SPI_SS3,
	input  logic              SPI_DI,
	input  osdPkg::vgaPixel_t videoIn,
	output osdPkg::vgaPixel_t videoOut,
	output logic              osdShown
);
	import osdPkg::*;

	bufWrite_t          bufWr;
	logic               osdEnable;
	videoPos_t          pos;
	osdWindow_t         window;
	logic [`BUF_AW-1:0] rdAddr;
	logic [7:0]         rdData;

	osdSpiRx uSpiRx (
		.SPI_SCK   (SPI_SCK),
		.SPI_SS3   (SPI_SS3),
		.SPI_DI    (SPI_DI),
		.bufWr     (bufWr),
		.osdEnable (osdEnable)
	);

	osdSyncMeasure uSyncMeasure (
		.clk_sys (clk_sys),
		.videoIn (videoIn),
		.pos     (pos),
		.window  (window)
	);

	osdBuffer uBuffer (
		.SPI_SCK (SPI_SCK),
		.bufWr   (bufWr),
		.clk_sys (clk_sys),
		.rdAddr  (rdAddr),
		.rdData  (rdData)
	);

	osdPixelPath uPixelPath (
		.clk_sys   (clk_sys),
		.osdEnable (osdEnable),
		.videoIn   (videoIn),
		.pos       (pos),
		.window    (window),
		.rdAddr    (rdAddr),
		.rdData    (rdData),
		.videoOut  (videoOut),
		.osdShown  (osdShown)
	);

endmodule

`default_nettype wire

//--- sim/osdAssert.sv
// OSD checker
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdAssert (
	input logic              clk_sys,
	input osdPkg::vgaPixel_t videoIn,
	input osdPkg::vgaPixel_t videoOut,
	input logic              osdShown,
	input logic              osdEnable,
	input logic              overlay
);
	import osdPkg::*;

	localparam logic [5:0] COL = `OSD_COLOR;

	logic [2:0]        warm = '0;
	logic              live;
	vgaPixel_t         inQ = '0;
	logic              shownQ = 1'b0;
	logic              ovlQ = 1'b0;
	logic              hsPrev = 1'b0;
	logic              vsPrev = 1'b0;
	logic              hsFall;
	logic              vsFall;
	logic [`CNT_W-1:0] pixCnt = '0;
	logic [`CNT_W-1:0] lineCnt = '0;

	// top bits doubled, tint pair with low bit flipped, input msbs at the bottom
	function automatic logic chanOk(input logic [5:0] ch, input logic [1:0] pair,
		input logic [5:0] prev);
		return (ch[5] == ch[4]) && (ch[3:2] == (pair ^ 2'b01)) && (ch[1:0] == prev[5:4]);
	endfunction

	assign live   = (warm == 3'd7);
	assign hsFall = hsPrev && !videoOut.hSync;
	assign vsFall = vsPrev && !videoOut.vSync;

	always_ff @(posedge clk_sys) begin
		if (!live)
			warm <= warm + 1'b1;
		inQ    <= videoIn;
		shownQ <= osdShown;
		ovlQ   <= overlay;
		hsPrev <= videoOut.hSync;
		vsPrev <= videoOut.vSync;
		if (hsFall)
			pixCnt <= '0;
		else if (ovlQ)
			pixCnt <= pixCnt + 1'b1;
		if (vsFall)
			lineCnt <= '0;
		else if (hsFall && (pixCnt != '0))
			lineCnt <= lineCnt + 1'b1;
	end

	// ******************************
	// video path
	// ******************************
	syncDelay: assert property (@(posedge clk_sys) disable iff (!live)
		{videoOut.hSync, videoOut.vSync} == {inQ.hSync, inQ.vSync})
	else begin
		$error("ERR %0t videoOut syncs exp %b got %b", $time,
			{$sampled(inQ.hSync), $sampled(inQ.vSync)}, {videoOut.hSync, videoOut.vSync});
		osdTb.errCount++;
	end

	passThrough: assert property (@(posedge clk_sys) disable iff (!live)
		!shownQ |-> videoOut == inQ)
	else begin
		$error("ERR %0t videoOut exp %h got %h", $time, $sampled(inQ), videoOut);
		osdTb.errCount++;
	end

	overlayForm: assert property (@(posedge clk_sys) disable iff (!live)
		(videoOut != inQ) |-> shownQ && chanOk(videoOut.red, COL[5:4], inQ.red) &&
			chanOk(videoOut.green, COL[3:2], inQ.green) &&
			chanOk(videoOut.blue, COL[1:0], inQ.blue))
	else begin
		$error("ERR %0t videoOut overlay form, input %h got %h", $time, $sampled(inQ),
			videoOut);
		osdTb.errCount++;
	end

	fillPixel: assert property (@(posedge clk_sys) disable iff (!live)
		(osdTb.fillCheck && ovlQ) |->
			{videoOut.red[5:4], videoOut.green[5:4], videoOut.blue[5:4]} ==
			{6{osdTb.fillBit}})
	else begin
		$error("ERR %0t videoOut pixel bits exp %b got %b", $time,
			{6{$sampled(osdTb.fillBit)}},
			{videoOut.red[5:4], videoOut.green[5:4], videoOut.blue[5:4]});
		osdTb.errCount++;
	end

	// ******************************
	// enable and window size
	// ******************************
	enableRise: assert property (@(posedge clk_sys) disable iff (!live)
		$rose(osdEnable) |-> ##[1:3] osdShown)
	else begin
		$error("osdShown did not rise within 3 cycles of the enable command");
		osdTb.errCount++;
	end

	enableFall: assert property (@(posedge clk_sys) disable iff (!live)
		$fell(osdEnable) |-> ##[1:3] !osdShown)
	else begin
		$error("osdShown did not fall within 3 cycles of the disable command");
		osdTb.errCount++;
	end

	lineWidth: assert property (@(posedge clk_sys) disable iff (!live)
		(osdTb.sizeCheck && hsFall) |-> (pixCnt == '0) || (pixCnt == `OSD_WIDTH))
	else begin
		$error("ERR %0t overlay pixels per line exp %0d got %0d", $time, `OSD_WIDTH,
			$sampled(pixCnt));
		osdTb.errCount++;
	end

	frameHeight: assert property (@(posedge clk_sys) disable iff (!live)
		(osdTb.sizeCheck && vsFall) |-> lineCnt == osdTb.expectLines)
	else begin
		$error("ERR %0t overlay lines per frame exp %0d got %0d", $time,
			$sampled(osdTb.expectLines), $sampled(lineCnt));
		osdTb.errCount++;
	end

endmodule

`default_nettype wire

//--- sim/osdTb.sv
// OSD testbench
`timescale 1ns/1ps
`default_nettype none
`include "osdParams.svh"

module osdTb;
	import osdPkg::*;

	localparam int LINE_LEN = 300;
	localparam int HS_LEN   = 8;
	localparam int VBLANK   = 20;
	localparam int FRAME_S  = LINE_LEN * (200 + VBLANK);
	localparam int FRAME_D  = LINE_LEN * (400 + VBLANK);
	// two buffer fills plus a few commands, 32 clk_sys cycles per byte
	localparam int SPI_CYC  = (2 * 2049 + 8) * 32;
	localparam int LIMIT    = (7 * FRAME_S + 5 * FRAME_D + SPI_CYC) * 5 / 4;

	logic      clk_sys = 1'b0;
	logic      SPI_SCK = 1'b0;
	logic      SPI_SS3 = 1'b0;
	logic      SPI_DI = 1'b0;
	vgaPixel_t videoIn = '0;
	vgaPixel_t videoOut;
	logic      osdShown;

	int          errCount = 0;
	int          cycles = 0;
	logic        sizeCheck = 1'b0;
	int          expectLines = 0;
	logic        fillCheck = 1'b0;
	logic        fillBit = 1'b0;
	int          activeLines = 200;
	int          curActive = 200;
	int          pixIdx = 0;
	int          lineIdx = 0;
	logic [31:0] lcgState = 32'd27292;

	osdTop dut (
		.clk_sys  (clk_sys),
		.SPI_SCK  (SPI_SCK),
		.SPI_SS3  (SPI_SS3),
		.SPI_DI   (SPI_DI),
		.videoIn  (videoIn),
		.videoOut (videoOut),
		.osdShown (osdShown)
	);

	bind osdTop osdAssert chk (
		.clk_sys   (clk_sys),
		.videoIn   (videoIn),
		.videoOut  (videoOut),
		.osdShown  (osdShown),
		.osdEnable (osdEnable),
		.overlay   (uPixelPath.osdDe)
	);

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		forever #2 clk_sys = ~clk_sys;
	end

	// ******************************
	// video generator
	// ******************************
	initial begin
		forever begin
			@(posedge clk_sys);
			#1;
			// frame height only changes at a frame boundary
			if (pixIdx == 0 && lineIdx == 0)
				curActive = activeLines;
			lcgState      = lcgNext(lcgState);
			videoIn.red   = lcgState[31:26];
			videoIn.green = lcgState[25:20];
			videoIn.blue  = lcgState[19:14];
			videoIn.hSync = (pixIdx >= HS_LEN);
			videoIn.vSync = (lineIdx < curActive);
			if (pixIdx == LINE_LEN - 1) begin
				pixIdx = 0;
				if (lineIdx == curActive + VBLANK - 1)
					lineIdx = 0;
				else
					lineIdx++;
			end else begin
				pixIdx++;
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d clk_sys cycles", LIMIT);
			$display("errors: %0d assertion failures, 1 timeout", errCount);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic waitFrames(input int n);
		repeat (n) begin
			do @(posedge clk_sys); while (!(pixIdx == 0 && lineIdx == 0));
		end
	endtask

	// ******************************
	// spi master, sck at clk_sys / 4
	// ******************************
	task automatic spiByte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			#1;
			SPI_SCK = 1'b0;
			SPI_DI  = b[i];
			@(posedge clk_sys);
			@(posedge clk_sys);
			#1;
			SPI_SCK = 1'b1;
			@(posedge clk_sys);
		end
	endtask

	task automatic spiSelect;
		@(posedge clk_sys);
		#1;
		SPI_SS3 = 1'b0;
	endtask

	task automatic spiRelease;
		@(posedge clk_sys);
		#1;
		SPI_SCK = 1'b0;
		@(posedge clk_sys);
		#1;
		SPI_SS3 = 1'b1;
	endtask

	task automatic spiCommand(input logic [7:0] cmd);
		spiSelect();
		spiByte(cmd);
		spiRelease();
	endtask

	// write command for line 0, then the address runs through all 2048 bytes
	task automatic fillBuffer(input logic [7:0] val);
		spiSelect();
		spiByte({`CMD_WRITE, 3'd0});
		repeat (2048) spiByte(val);
		spiRelease();
	endtask

	task automatic checkFrame(input int lines);
		waitFrames(1);
		expectLines = lines;
		sizeCheck   = 1'b1;
		waitFrames(1);
		sizeCheck = 1'b0;
	endtask

	initial begin
		// the rising edge of the select clears the spi receiver
		#1;
		SPI_SS3 = 1'b1;
		repeat (2) @(posedge clk_sys);
		fillBuffer(8'hFF);
		waitFrames(2);
		spiCommand(8'h41);
		fillBit   = 1'b1;
		fillCheck = 1'b1;
		checkFrame(`OSD_HEIGHT);
		fillCheck = 1'b0;
		fillBuffer(8'h00);
		waitFrames(1);
		fillBit   = 1'b0;
		fillCheck = 1'b1;
		waitFrames(1);
		fillCheck = 1'b0;
		spiCommand(8'h40);
		waitFrames(1);
		// doublescan mode
		activeLines = 400;
		waitFrames(3);
		spiCommand(8'h41);
		fillCheck = 1'b1;
		checkFrame(2 * `OSD_HEIGHT);
		fillCheck = 1'b0;
		spiCommand(8'h40);
		repeat (10) @(posedge clk_sys);
		$display("errors: %0d assertion failures, 0 timeouts", errCount);
		if (errCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+design
design/osdPkg.sv
design/osdSpiRx.sv
design/osdSyncMeasure.sv
design/osdBuffer.sv
design/osdPixelPath.sv
design/osdTop.sv
sim/osdAssert.sv
sim/osdTb.sv

//--- Bender.yml
package:
  name: osd

sources:
  - include_dirs:
      - design
    files:
      - design/osdPkg.sv
      - design/osdSpiRx.sv
      - design/osdSyncMeasure.sv
      - design/osdBuffer.sv
      - design/osdPixelPath.sv
      - design/osdTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/osdAssert.sv
      - sim/osdTb.sv
